// File: verilog/copper_pkg.sv
// shared definitions for the copper subsystem
// opcode and sequencer state enums, bus widths,
// and the bit positions of each instruction field

package copper_pkg;

    // widths
    localparam int instr_w     = 16;
    localparam int reg_addr_w  = 6;
    localparam int raster_x_w  = 11;
    localparam int raster_y_w  = 10;
    localparam int prog_addr_w = 11;

    typedef enum logic [1:0] {
        op_set_target       = 2'd0,
        op_write_compressed = 2'd1,
        op_write_reg        = 2'd2,
        op_jump             = 2'd3
    } copper_op_e;

    typedef enum logic [1:0] {
        st_decode,
        st_data_fetch,
        st_raster_wait,
        st_prefetch
    } copper_state_e;

    // common opcode field
    localparam int op_msb = 15;
    localparam int op_lsb = 14;

    // set target: oo-wsvvv vvvvvvvv
    localparam int tgt_wait_bit = 12;
    localparam int tgt_sel_bit  = 11;
    localparam int tgt_val_msb  = 10;
    localparam int tgt_val_lsb  = 0;

    // write reg: ooiiynnn nnrrrrrr
    localparam int wr_inc_msb       = 13;
    localparam int wr_inc_lsb       = 12;
    localparam int wr_auto_wait_bit = 11;
    localparam int wr_count_msb     = 10;
    localparam int wr_count_lsb     = 6;
    localparam int wr_reg_msb       = 5;
    localparam int wr_reg_lsb       = 0;

    // compressed write: oo--yddd ddrrrrrr
    localparam int cw_auto_y_bit = 11;
    localparam int cw_data_msb   = 10;
    localparam int cw_data_lsb   = 6;

    // jump target
    localparam int jmp_msb = 10;
    localparam int jmp_lsb = 0;

endpackage

// File: verilog/raster_timer.sv
// beam position generator
// wrapping horizontal and vertical counters plus the horizontal blanking flag

`timescale 1ns/1ps

module raster_timer import copper_pkg::*; #(
    parameter int h_total  = 64,
    parameter int v_total  = 32,
    parameter int h_active = 48
) (
    input  logic                  clk,
    input  logic                  arst_n,
    output logic [raster_x_w-1:0] raster_x,
    output logic [raster_y_w-1:0] raster_y,
    output logic                  h_blank
);

    localparam logic [raster_x_w-1:0] x_last = raster_x_w'(h_total - 1);
    localparam logic [raster_y_w-1:0] y_last = raster_y_w'(v_total - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (raster_x == x_last) begin
            raster_x <= '0;
            // end of line, step to the next one
            if (raster_y == y_last) begin
                raster_y <= '0;
            end else begin
                raster_y <= raster_y + 1'b1;
            end
        end else begin
            raster_x <= raster_x + 1'b1;
        end
    end

    // right border and retrace
    assign h_blank = (raster_x >= raster_x_w'(h_active));

endmodule

// File: verilog/copper_ram.sv
// copper program memory
// host write port for loading, registered read port for instruction fetch

`timescale 1ns/1ps

module copper_ram import copper_pkg::*; #(
    parameter int prog_depth = 2048
) (
    input  logic                   clk,
    input  logic                   load_en,
    input  logic [prog_addr_w-1:0] load_addr,
    input  logic [instr_w-1:0]     load_data,
    input  logic                   ram_en,
    input  logic [prog_addr_w-1:0] ram_addr,
    output logic [instr_w-1:0]     ram_data
);

    logic [instr_w-1:0] mem [prog_depth];

    // host side
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // copper side, data one cycle after the address
    always_ff @(posedge clk) begin
        if (ram_en) begin
            ram_data <= mem[ram_addr];
        end
    end

endmodule

// File: verilog/copper_sequencer.sv
// copper instruction sequencer
// fetch, decode and raster wait FSM, batched register writes,
// credit counter for the write channel to the register bank

`timescale 1ns/1ps

module copper_sequencer import copper_pkg::*; #(
    parameter int credits = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   enable,
    input  logic [raster_x_w-1:0]  raster_x,
    input  logic [raster_y_w-1:0]  raster_y,
    output logic [prog_addr_w-1:0] ram_addr,
    output logic                   ram_en,
    input  logic [instr_w-1:0]     ram_data,
    output logic                   wr_valid,
    output logic [reg_addr_w-1:0]  wr_addr,
    output logic [instr_w-1:0]     wr_data,
    input  logic                   credit_return
);

    localparam int credit_w = $clog2(credits + 1);

    copper_state_e          state_q, state_d;
    copper_op_e             op, op_q, op_d;
    logic [prog_addr_w-1:0] pc_q, pc_d;
    logic [raster_x_w-1:0]  target_x_q, target_x_d;
    logic [raster_y_w-1:0]  target_y_q, target_y_d;
    logic [4:0]             batch_cnt_q, batch_cnt_d;
    logic [1:0]             wr_cnt_q, wr_cnt_d;
    logic [credit_w-1:0]    credit_cnt;

    // write reg fields held while the data words stream
    logic [reg_addr_w-1:0]  wr_reg_q;
    logic [1:0]             inc_mode_q;
    logic                   auto_wait_q;
    logic                   ld_write_reg;

    logic                   issue;
    logic [reg_addr_w-1:0]  issue_addr;
    logic [instr_w-1:0]     issue_data;
    logic [1:0]             reg_offset;
    logic                   batch_done;
    logic                   target_hit;
    logic                   credit_ok;

    assign op         = copper_op_e'(ram_data[op_msb:op_lsb]);
    assign target_hit = (target_x_q == raster_x) && (target_y_q == raster_y);
    assign credit_ok  = (credit_cnt != '0);

    // batch size from increment mode, mode 3 behaves as mode 0
    always_comb begin
        case (inc_mode_q)
            2'd1: begin
                reg_offset = {1'b0, wr_cnt_q[0]};
                batch_done = wr_cnt_q[0];
            end
            2'd2: begin
                reg_offset = wr_cnt_q;
                batch_done = (wr_cnt_q == 2'd3);
            end
            default: begin
                reg_offset = 2'd0;
                batch_done = 1'b1;
            end
        endcase
    end

    always_comb begin
        state_d      = state_q;
        op_d         = op_q;
        pc_d         = pc_q;
        target_x_d   = target_x_q;
        target_y_d   = target_y_q;
        batch_cnt_d  = batch_cnt_q;
        wr_cnt_d     = wr_cnt_q;
        ld_write_reg = 1'b0;
        issue        = 1'b0;
        issue_addr   = wr_reg_q + reg_addr_w'(reg_offset);
        issue_data   = ram_data;

        if (!enable) begin
            state_d     = st_prefetch;
            pc_d        = '0;
            target_x_d  = '0;
            target_y_d  = '0;
            batch_cnt_d = '0;
            wr_cnt_d    = '0;
        end else begin
            case (state_q)
                st_decode: begin
                    op_d = op;
                    case (op)
                        op_set_target: begin
                            if (ram_data[tgt_sel_bit]) begin
                                target_y_d = ram_data[raster_y_w-1:0];
                            end else begin
                                target_x_d = ram_data[tgt_val_msb:tgt_val_lsb];
                            end
                            if (ram_data[tgt_wait_bit]) begin
                                state_d = st_raster_wait;
                            end else begin
                                pc_d = pc_q + 1'b1;
                            end
                        end
                        op_write_compressed: begin
                            // hold here until the bank has room
                            if (credit_ok) begin
                                issue      = 1'b1;
                                issue_addr = ram_data[wr_reg_msb:wr_reg_lsb];
                                issue_data = instr_w'(ram_data[cw_data_msb:cw_data_lsb]);
                                if (ram_data[cw_auto_y_bit]) begin
                                    target_y_d = raster_y + 1'b1;
                                end
                                pc_d = pc_q + 1'b1;
                            end
                        end
                        op_write_reg: begin
                            ld_write_reg = 1'b1;
                            batch_cnt_d  = ram_data[wr_count_msb:wr_count_lsb];
                            wr_cnt_d     = '0;
                            state_d      = st_data_fetch;
                            pc_d         = pc_q + 1'b1;
                        end
                        default: begin
                            pc_d    = ram_data[jmp_msb:jmp_lsb];
                            state_d = st_prefetch;
                        end
                    endcase
                end
                st_data_fetch: begin
                    if (credit_ok) begin
                        issue    = 1'b1;
                        wr_cnt_d = wr_cnt_q + 1'b1;
                        if (!batch_done) begin
                            pc_d = pc_q + 1'b1;
                        end else if (batch_cnt_q == '0) begin
                            state_d = st_decode;
                            pc_d    = pc_q + 1'b1;
                        end else begin
                            batch_cnt_d = batch_cnt_q - 1'b1;
                            if (auto_wait_q) begin
                                // next batch on the following line
                                target_y_d = raster_y + 1'b1;
                                state_d    = st_raster_wait;
                            end else begin
                                pc_d = pc_q + 1'b1;
                            end
                        end
                    end
                end
                st_raster_wait: begin
                    if (target_hit) begin
                        if (op_q == op_write_reg && auto_wait_q) begin
                            state_d = st_data_fetch;
                        end else begin
                            state_d = st_decode;
                        end
                        pc_d = pc_q + 1'b1;
                    end
                end
                default: begin
                    state_d = st_decode;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state_q     <= st_prefetch;
            op_q        <= op_set_target;
            pc_q        <= '0;
            target_x_q  <= '0;
            target_y_q  <= '0;
            batch_cnt_q <= '0;
            wr_cnt_q    <= '0;
            wr_valid    <= 1'b0;
        end else begin
            state_q     <= state_d;
            op_q        <= op_d;
            pc_q        <= pc_d;
            target_x_q  <= target_x_d;
            target_y_q  <= target_y_d;
            batch_cnt_q <= batch_cnt_d;
            wr_cnt_q    <= wr_cnt_d;
            wr_valid    <= issue;
        end
    end

    // credits keep counting with enable low, entries may still be draining
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            credit_cnt <= credit_w'(credits);
        end else if (issue && !credit_return) begin
            credit_cnt <= credit_cnt - 1'b1;
        end else if (!issue && credit_return) begin
            credit_cnt <= credit_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_write_reg) begin
            wr_reg_q    <= ram_data[wr_reg_msb:wr_reg_lsb];
            inc_mode_q  <= ram_data[wr_inc_msb:wr_inc_lsb];
            auto_wait_q <= ram_data[wr_auto_wait_bit];
        end
        if (issue) begin
            wr_addr <= issue_addr;
            wr_data <= issue_data;
        end
    end

    // address the next pc so data matches pc in the following cycle
    assign ram_addr = pc_d;
    assign ram_en   = enable;

endmodule

// File: verilog/vdp_reg_bank.sv
// display register bank
// write FIFO drained only during horizontal blanking, one credit per commit,
// 64 x 16 register array with combinational readback

`timescale 1ns/1ps

module vdp_reg_bank import copper_pkg::*; #(
    parameter int credits = 4
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  h_blank,
    input  logic                  wr_valid,
    input  logic [reg_addr_w-1:0] wr_addr,
    input  logic [instr_w-1:0]    wr_data,
    output logic                  credit_return,
    input  logic [reg_addr_w-1:0] rd_addr,
    output logic [instr_w-1:0]    rd_data
);

    localparam int ptr_w = (credits > 1) ? $clog2(credits) : 1;
    localparam int cnt_w = $clog2(credits + 1);
    localparam logic [ptr_w-1:0] ptr_last = ptr_w'(credits - 1);

    logic [reg_addr_w-1:0] fifo_addr [credits];
    logic [instr_w-1:0]    fifo_data [credits];
    logic [ptr_w-1:0]      wr_ptr, rd_ptr;
    logic [cnt_w-1:0]      count;
    logic [instr_w-1:0]    regs [2**reg_addr_w];
    logic                  pop;

    // sender holds a credit for every push, so no full check
    assign pop           = h_blank && (count != '0);
    assign credit_return = pop;

    always_ff @(posedge clk) begin
        if (wr_valid) begin
            fifo_addr[wr_ptr] <= wr_addr;
            fifo_data[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_valid) begin
                wr_ptr <= (wr_ptr == ptr_last) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_last) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_valid && !pop) begin
                count <= count + 1'b1;
            end else if (!wr_valid && pop) begin
                count <= count - 1'b1;
            end
        end
    end

    // commit in order while the beam is outside the active area
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (pop) begin
            regs[fifo_addr[rd_ptr]] <= fifo_data[rd_ptr];
        end
    end

    assign rd_data = regs[rd_addr];

endmodule

// File: verilog/copper_top.sv
// copper subsystem top level
// raster timer, program RAM, sequencer and register bank,
// with the geometry and FIFO depth passed down

`timescale 1ns/1ps

module copper_top import copper_pkg::*; #(
    parameter int prog_depth = 2048,
    parameter int h_total    = 64,
    parameter int v_total    = 32,
    parameter int h_active   = 48,
    parameter int credits    = 4
) (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   enable,
    input  logic                   load_en,
    input  logic [prog_addr_w-1:0] load_addr,
    input  logic [instr_w-1:0]     load_data,
    input  logic [reg_addr_w-1:0]  rd_addr,
    output logic [instr_w-1:0]     rd_data
);

    logic [raster_x_w-1:0]  raster_x;
    logic [raster_y_w-1:0]  raster_y;
    logic                   h_blank;
    logic [prog_addr_w-1:0] ram_addr;
    logic                   ram_en;
    logic [instr_w-1:0]     ram_data;
    logic                   wr_valid;
    logic [reg_addr_w-1:0]  wr_addr;
    logic [instr_w-1:0]     wr_data;
    logic                   credit_return;

    raster_timer #(
        .h_total  (h_total),
        .v_total  (v_total),
        .h_active (h_active)
    ) i_timer (
        .clk      (clk),
        .arst_n   (arst_n),
        .raster_x (raster_x),
        .raster_y (raster_y),
        .h_blank  (h_blank)
    );

    copper_ram #(
        .prog_depth (prog_depth)
    ) i_ram (
        .clk       (clk),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .ram_en    (ram_en),
        .ram_addr  (ram_addr),
        .ram_data  (ram_data)
    );

    copper_sequencer #(
        .credits (credits)
    ) i_seq (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable        (enable),
        .raster_x      (raster_x),
        .raster_y      (raster_y),
        .ram_addr      (ram_addr),
        .ram_en        (ram_en),
        .ram_data      (ram_data),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .credit_return (credit_return)
    );

    // writes land here only during blanking
    vdp_reg_bank #(
        .credits (credits)
    ) i_bank (
        .clk           (clk),
        .arst_n        (arst_n),
        .h_blank       (h_blank),
        .wr_valid      (wr_valid),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .credit_return (credit_return),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data)
    );

endmodule

// File: tb/tb_copper.sv
// testbench for the copper subsystem
// program builder, reference interpreter, register readback and compare,
// per test reporting and a watchdog

`timescale 1ns/1ps

module tb_copper import copper_pkg::*; ();

    localparam int h_total      = 64;
    localparam int v_total      = 32;
    localparam int h_active     = 48;
    localparam int credits      = 4;
    localparam int num_tests    = 6;
    localparam int frame_cycles = h_total * v_total;
    localparam int watchdog_ns  = num_tests * 3 * frame_cycles * 10;

    logic                   clk;
    logic                   arst_n;
    logic                   enable;
    logic                   load_en;
    logic [prog_addr_w-1:0] load_addr;
    logic [instr_w-1:0]     load_data;
    logic [reg_addr_w-1:0]  rd_addr;
    logic [instr_w-1:0]     rd_data;

    logic [instr_w-1:0] prog [$];
    logic [instr_w-1:0] expected [64];
    string              test_name;
    int                 mismatches;
    int                 tests_passed;
    int                 tests_failed;
    int                 data_seq;
    event               compare_start;
    event               compare_done;

    copper_top #(
        .h_total  (h_total),
        .v_total  (v_total),
        .h_active (h_active),
        .credits  (credits)
    ) i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .enable    (enable),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    always #5 clk = ~clk;

    // instruction encoders
    function automatic logic [15:0] target_word(input bit wait_en, input bit sel_y,
                                                input logic [10:0] val);
        return {op_set_target, 1'b0, wait_en, sel_y, val};
    endfunction

    function automatic logic [15:0] compressed_word(input bit auto_y, input logic [4:0] data,
                                                    input logic [5:0] reg_num);
        return {op_write_compressed, 2'b00, auto_y, data, reg_num};
    endfunction

    function automatic logic [15:0] write_word(input logic [1:0] mode, input bit auto_wait,
                                               input logic [4:0] count,
                                               input logic [5:0] reg_num);
        return {op_write_reg, mode, auto_wait, count, reg_num};
    endfunction

    function automatic logic [15:0] jump_word(input logic [10:0] target);
        return {op_jump, 3'b000, target};
    endfunction

    task automatic append_data_words(input int n);
        logic [15:0] w;
        for (int i = 0; i < n; i++) begin
            w = 16'h1000 + data_seq * 37;
            prog.push_back(w);
            data_seq++;
        end
    endtask

    // program order interpreter that ignores timing
    function automatic void ref_run();
        int          pc;
        int          steps;
        int          size;
        int          batches;
        logic [15:0] w;
        bit          stopped;
        pc      = 0;
        steps   = 0;
        stopped = 1'b0;
        while (!stopped && steps < 10000) begin
            w = prog[pc];
            steps++;
            case (w[15:14])
                op_set_target: begin
                    pc++;
                end
                op_write_compressed: begin
                    expected[w[5:0]] = {11'd0, w[10:6]};
                    pc++;
                end
                op_write_reg: begin
                    // batch of 1, 2 or 4 registers with mode 3 as mode 0
                    case (w[13:12])
                        2'd1: size = 2;
                        2'd2: size = 4;
                        default: size = 1;
                    endcase
                    batches = w[10:6] + 1;
                    pc++;
                    for (int b = 0; b < batches; b++) begin
                        for (int k = 0; k < size; k++) begin
                            expected[(w[5:0] + k) % 64] = prog[pc];
                            pc++;
                        end
                    end
                end
                default: begin
                    if (w[10:0] == pc) begin
                        stopped = 1'b1;
                    end else begin
                        pc = w[10:0];
                    end
                end
            endcase
        end
    endfunction

    task automatic apply_reset();
        @(posedge clk);
        #1;
        arst_n = 1'b0;
        enable = 1'b0;
        repeat (10) @(posedge clk);
        #1 arst_n = 1'b1;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog.size(); i++) begin
            @(posedge clk);
            #1;
            load_en   = 1'b1;
            load_addr = i;
            load_data = prog[i];
        end
        @(posedge clk);
        #1 load_en = 1'b0;
    endtask

    task automatic run_test(input string name, input bit run_en);
        apply_reset();
        load_program();
        for (int i = 0; i < 64; i++) begin
            expected[i] = '0;
        end
        if (run_en) begin
            ref_run();
        end
        @(posedge clk);
        #1 enable = run_en;
        // two frames cover every wait and the blanking drain
        repeat (2 * frame_cycles) @(posedge clk);
        test_name  = name;
        mismatches = 0;
        -> compare_start;
        @(compare_done);
        if (mismatches == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d register mismatches", name, mismatches);
        end
    endtask

    // readback of all 64 registers against the reference
    always begin
        @(compare_start);
        for (int i = 0; i < 64; i++) begin
            @(posedge clk);
            #1 rd_addr = i;
            @(negedge clk);
            if (rd_data !== expected[i]) begin
                $display("CHECK FAILED test %s reg %0d expected %04h actual %04h",
                         test_name, i, expected[i], rd_data);
                mismatches++;
            end
        end
        -> compare_done;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired, the copper run hung");
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        logic [5:0]  rnd_reg;
        logic [15:0] rnd_data;
        void'($urandom(48));
        clk          = 1'b0;
        arst_n       = 1'b0;
        enable       = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        rd_addr      = '0;
        tests_passed = 0;
        tests_failed = 0;
        data_seq     = 0;

        // compressed writes with some auto increment y
        prog.delete();
        prog.push_back(compressed_word(1'b0, 5'h1f, 6'd3));
        prog.push_back(compressed_word(1'b1, 5'h0a, 6'd10));
        prog.push_back(compressed_word(1'b0, 5'h11, 6'd63));
        prog.push_back(compressed_word(1'b1, 5'h03, 6'd10));
        prog.push_back(compressed_word(1'b0, 5'h15, 6'd0));
        prog.push_back(jump_word(11'd5));
        run_test("compressed", 1'b1);

        // batched writes over all increment modes
        prog.delete();
        prog.push_back(write_word(2'd0, 1'b0, 5'd2, 6'd1));
        append_data_words(3);
        prog.push_back(write_word(2'd1, 1'b0, 5'd1, 6'd8));
        append_data_words(4);
        prog.push_back(write_word(2'd2, 1'b0, 5'd3, 6'd20));
        append_data_words(16);
        prog.push_back(write_word(2'd2, 1'b0, 5'd0, 6'd62));
        append_data_words(4);
        prog.push_back(write_word(2'd3, 1'b0, 5'd1, 6'd40));
        append_data_words(2);
        prog.push_back(write_word(2'd1, 1'b1, 5'd3, 6'd30));
        append_data_words(8);
        prog.push_back(jump_word(prog.size()));
        run_test("batched", 1'b1);

        // raster waits on y then x, and a target without wait
        prog.delete();
        prog.push_back(target_word(1'b1, 1'b1, 11'd5));
        prog.push_back(compressed_word(1'b0, 5'd7, 6'd12));
        prog.push_back(target_word(1'b1, 1'b0, 11'd30));
        prog.push_back(write_word(2'd0, 1'b0, 5'd0, 6'd13));
        prog.push_back(16'hbeef);
        prog.push_back(target_word(1'b0, 1'b1, 11'd9));
        prog.push_back(compressed_word(1'b0, 5'd9, 6'd14));
        prog.push_back(target_word(1'b1, 1'b0, 11'd50));
        prog.push_back(compressed_word(1'b0, 5'd2, 6'd12));
        prog.push_back(jump_word(11'd9));
        run_test("raster_wait", 1'b1);

        // jumps over blocks that must never land
        prog.delete();
        prog.push_back(compressed_word(1'b0, 5'd1, 6'd2));
        prog.push_back(jump_word(11'd5));
        prog.push_back(compressed_word(1'b0, 5'd31, 6'd2));
        prog.push_back(write_word(2'd0, 1'b0, 5'd0, 6'd3));
        prog.push_back(16'hdead);
        prog.push_back(compressed_word(1'b0, 5'd4, 6'd4));
        prog.push_back(jump_word(11'd9));
        prog.push_back(compressed_word(1'b0, 5'd5, 6'd4));
        prog.push_back(compressed_word(1'b0, 5'd6, 6'd5));
        prog.push_back(jump_word(11'd9));
        run_test("jump", 1'b1);

        // 40 random writes into 16 registers overrun the FIFO many times
        prog.delete();
        for (int i = 0; i < 40; i++) begin
            rnd_reg  = $urandom % 16;
            rnd_data = $urandom;
            prog.push_back(write_word(2'd0, 1'b0, 5'd0, rnd_reg));
            prog.push_back(rnd_data);
        end
        prog.push_back(jump_word(11'd80));
        run_test("backpressure", 1'b1);

        // program loaded but never started
        prog.delete();
        prog.push_back(compressed_word(1'b0, 5'd31, 6'd7));
        prog.push_back(compressed_word(1'b0, 5'd1, 6'd8));
        prog.push_back(jump_word(11'd2));
        run_test("enable_low", 1'b0);

        $display("tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: all.f
verilog/copper_pkg.sv
verilog/raster_timer.sv
verilog/copper_ram.sv
verilog/copper_sequencer.sv
verilog/vdp_reg_bank.sv
verilog/copper_top.sv
tb/tb_copper.sv

// File: Bender.yml
package:
  name: copper

sources:
  - verilog/copper_pkg.sv
  - verilog/raster_timer.sv
  - verilog/copper_ram.sv
  - verilog/copper_sequencer.sv
  - verilog/vdp_reg_bank.sv
  - verilog/copper_top.sv
  - target: test
    files:
      - tb/tb_copper.sv
